//--- rtl/reg_bus_pkg.sv
// register bus definitions
// widths of the command port and the internal request bus,
// plus the opcode and access FSM encodings

package reg_bus_pkg;

  // bus widths
  localparam int ADDR_W = 3;
  localparam int DATA_W = 16;

  // command opcodes
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } reg_op_e;

  // access port FSM states
  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } access_state_e;

endpackage

//--- rtl/board_map_pkg.sv
// board register map
// addresses, field positions and pin widths of the radio board
// GPIO controller

package board_map_pkg;

  //********************************************************************
  // register addresses
  //********************************************************************
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_BOARD_CTRL  = 3'd0;
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_BOARD_IN    = 3'd1;
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_RADIO0_CTRL = 3'd2;
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_RADIO1_CTRL = 3'd3;
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_RADIO0_STAT = 3'd4;
  localparam logic [reg_bus_pkg::ADDR_W-1:0] ADDR_RADIO1_STAT = 3'd5;

  // board pin widths
  localparam int BD_OUT_W     = 4;
  localparam int BD_IN_W      = 8;
  localparam int RADIO_CTL_W  = 4;
  localparam int RADIO_STAT_W = 8;
  localparam int SPI_CS_W     = 3;

  // board control register fields
  localparam int FLD_BD_OUT   = 0;
  localparam int FLD_SYNC     = 4;
  localparam int FLD_SPI_SEL  = 5;
  localparam int BOARD_CTRL_W = 7;

  // radio control register fields
  localparam int FLD_CTL      = 0;
  localparam int FLD_AGC      = 4;
  localparam int FLD_ENABLE   = 5;
  localparam int FLD_TXNRX    = 6;
  localparam int FLD_RESETB   = 7;
  localparam int RADIO_REG_W  = 8;

  // spi chip select choice
  typedef enum logic [1:0] {
    SPI_NONE   = 2'd0,
    SPI_RADIO0 = 2'd1,
    SPI_RADIO1 = 2'd2,
    SPI_SYNTH  = 2'd3
  } spi_sel_e;

endpackage

//--- rtl/reg_bus_if.sv
// internal register request bus
// one access per cycle with req_valid high, answered combinationally
// by the register bank in the same cycle

interface reg_bus_if;
  import reg_bus_pkg::*;

  logic              req_valid;
  reg_op_e           op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              err;

  // access port side
  modport master (
    output req_valid, op, addr, wdata,
    input  rdata, err
  );

  // register bank side
  modport slave (
    input  req_valid, op, addr, wdata,
    output rdata, err
  );

endinterface

//--- rtl/reg_access_port.sv
// register access port
// valid/ready command front end, one command in flight, the bank
// access happens on the accept edge and the response follows a cycle later

module reg_access_port (
  input  logic                             s_ref_clk,
  input  logic                             s_axi_aresetn,
  input  logic                             cmd_valid_i,
  output logic                             cmd_ready_o,
  input  reg_bus_pkg::reg_op_e             cmd_op_i,
  input  logic [reg_bus_pkg::ADDR_W-1:0]   cmd_addr_i,
  input  logic [reg_bus_pkg::DATA_W-1:0]   cmd_wdata_i,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic [reg_bus_pkg::DATA_W-1:0]   rsp_rdata_o,
  output logic                             rsp_err_o,
  reg_bus_if.master                        bus
);
  import reg_bus_pkg::*;

  access_state_e state_q;
  access_state_e state_d;
  logic          ready_q;
  logic          accept;

  assign accept = cmd_valid_i & cmd_ready_o;

  // request goes straight to the bank on the accept cycle
  assign bus.req_valid = accept;
  assign bus.op        = cmd_op_i;
  assign bus.addr      = cmd_addr_i;
  assign bus.wdata     = cmd_wdata_i;

  //********************************************************************
  // access FSM
  //********************************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept) state_d = ST_RESP;
      ST_RESP: if (rsp_ready_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // ready is registered so it stays low until the first edge after reset
  always_ff @(posedge s_ref_clk or negedge s_axi_aresetn) begin
    if (s_axi_aresetn == 1'b0) begin
      state_q <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == ST_IDLE);
    end
  end

  assign cmd_ready_o = ready_q;
  assign rsp_valid_o = (state_q == ST_RESP);

  // response payload, captured on accept and held until taken
  always_ff @(posedge s_ref_clk) begin
    if (accept) begin
      rsp_rdata_o <= bus.rdata;
      rsp_err_o   <= bus.err;
    end
  end

  // never offering a response while taking a command
  a_one_in_flight: assert property (
    @(posedge s_ref_clk) disable iff (!s_axi_aresetn)
    !(rsp_valid_o && cmd_ready_o)
  );

  // stalled response keeps its payload
  a_rsp_hold: assert property (
    @(posedge s_ref_clk) disable iff (!s_axi_aresetn)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o)
  );

endmodule

//--- rtl/gpio_bank.sv
// gpio register bank
// board and radio control registers, status readback, address decode
// and the mapping of fields onto board, radio and spi select pins

module gpio_bank (
  input  logic                                   s_ref_clk,
  input  logic                                   s_axi_aresetn,
  reg_bus_if.slave                               bus,
  input  logic [board_map_pkg::BD_IN_W-1:0]      bd_in_i,
  input  logic [board_map_pkg::RADIO_STAT_W-1:0] radio0_stat_i,
  input  logic [board_map_pkg::RADIO_STAT_W-1:0] radio1_stat_i,
  output logic [board_map_pkg::BD_OUT_W-1:0]     bd_out_o,
  output logic                                   sync_req_o,
  output logic [board_map_pkg::RADIO_CTL_W-1:0]  radio0_ctl_o,
  output logic                                   radio0_agc_o,
  output logic                                   radio0_enable_o,
  output logic                                   radio0_txnrx_o,
  output logic                                   radio0_resetb_o,
  output logic [board_map_pkg::RADIO_CTL_W-1:0]  radio1_ctl_o,
  output logic                                   radio1_agc_o,
  output logic                                   radio1_enable_o,
  output logic                                   radio1_txnrx_o,
  output logic                                   radio1_resetb_o,
  output logic [board_map_pkg::SPI_CS_W-1:0]     spi_cs_n_o
);
  import reg_bus_pkg::*;
  import board_map_pkg::*;

  logic [BOARD_CTRL_W-1:0] board_ctrl_q;
  logic [RADIO_REG_W-1:0]  radio0_q;
  logic [RADIO_REG_W-1:0]  radio1_q;
  logic                    wr_en;
  spi_sel_e                spi_sel;

  assign wr_en = bus.req_valid && (bus.op == OP_WRITE);

  //********************************************************************
  // read decode and error rules
  //********************************************************************
  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.addr)
      ADDR_BOARD_CTRL:  bus.rdata = DATA_W'(board_ctrl_q);
      ADDR_RADIO0_CTRL: bus.rdata = DATA_W'(radio0_q);
      ADDR_RADIO1_CTRL: bus.rdata = DATA_W'(radio1_q);
      ADDR_BOARD_IN: begin
        bus.rdata = DATA_W'(bd_in_i);
        bus.err   = (bus.op == OP_WRITE);
      end
      ADDR_RADIO0_STAT: begin
        bus.rdata = DATA_W'(radio0_stat_i);
        bus.err   = (bus.op == OP_WRITE);
      end
      ADDR_RADIO1_STAT: begin
        bus.rdata = DATA_W'(radio1_stat_i);
        bus.err   = (bus.op == OP_WRITE);
      end
      // unmapped, reads zero
      default: bus.err = 1'b1;
    endcase
  end

  // writable registers, zero at reset keeps radios in reset
  always_ff @(posedge s_ref_clk or negedge s_axi_aresetn) begin
    if (s_axi_aresetn == 1'b0) begin
      board_ctrl_q <= '0;
      radio0_q     <= '0;
      radio1_q     <= '0;
    end else if (wr_en) begin
      case (bus.addr)
        ADDR_BOARD_CTRL:  board_ctrl_q <= bus.wdata[BOARD_CTRL_W-1:0];
        ADDR_RADIO0_CTRL: radio0_q <= bus.wdata[RADIO_REG_W-1:0];
        ADDR_RADIO1_CTRL: radio1_q <= bus.wdata[RADIO_REG_W-1:0];
        default: ;
      endcase
    end
  end

  //********************************************************************
  // field mapping
  //********************************************************************
  assign bd_out_o   = board_ctrl_q[FLD_BD_OUT +: BD_OUT_W];
  assign sync_req_o = board_ctrl_q[FLD_SYNC];
  assign spi_sel    = spi_sel_e'(board_ctrl_q[FLD_SPI_SEL +: $bits(spi_sel_e)]);

  assign radio0_ctl_o    = radio0_q[FLD_CTL +: RADIO_CTL_W];
  assign radio0_agc_o    = radio0_q[FLD_AGC];
  assign radio0_enable_o = radio0_q[FLD_ENABLE];
  assign radio0_txnrx_o  = radio0_q[FLD_TXNRX];
  assign radio0_resetb_o = radio0_q[FLD_RESETB];

  assign radio1_ctl_o    = radio1_q[FLD_CTL +: RADIO_CTL_W];
  assign radio1_agc_o    = radio1_q[FLD_AGC];
  assign radio1_enable_o = radio1_q[FLD_ENABLE];
  assign radio1_txnrx_o  = radio1_q[FLD_TXNRX];
  assign radio1_resetb_o = radio1_q[FLD_RESETB];

  // one-hot active low selects, bit 0 radio0, bit 1 radio1, bit 2 synth
  always_comb begin
    spi_cs_n_o = '1;
    case (spi_sel)
      SPI_RADIO0: spi_cs_n_o[0] = 1'b0;
      SPI_RADIO1: spi_cs_n_o[1] = 1'b0;
      SPI_SYNTH:  spi_cs_n_o[2] = 1'b0;
      default: ;
    endcase
  end

  a_single_cs: assert property (
    @(posedge s_ref_clk) disable iff (!s_axi_aresetn)
    $onehot0(~spi_cs_n_o)
  );

endmodule

//--- rtl/mcs_sync_gen.sv
// multi-chip sync generator
// resynchronizes the sync request and emits a one-cycle pulse
// on each falling edge of it

module mcs_sync_gen (
  input  logic s_ref_clk,
  input  logic s_axi_aresetn,
  input  logic sync_req_i,
  output logic mcs_sync_o
);

  logic [2:0] sync_q;
  logic       pulse_q;

  // three stage shift, pulse from the two oldest stages
  always_ff @(posedge s_ref_clk or negedge s_axi_aresetn) begin
    if (s_axi_aresetn == 1'b0) begin
      sync_q  <= 3'd0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[1:0], sync_req_i};
      pulse_q <= sync_q[2] & ~sync_q[1];
    end
  end

  assign mcs_sync_o = pulse_q;

  a_single_pulse: assert property (
    @(posedge s_ref_clk) disable iff (!s_axi_aresetn)
    mcs_sync_o |=> !mcs_sync_o
  );

endmodule

//--- rtl/radio_ctrl_top.sv
// radio board control plane top
// command port into the register bank, with multi-chip sync
// generation on the reference clock

module radio_ctrl_top (
  input  logic                                   s_ref_clk,
  input  logic                                   s_axi_aresetn,
  // command and response port
  input  logic                                   cmd_valid_i,
  output logic                                   cmd_ready_o,
  input  reg_bus_pkg::reg_op_e                   cmd_op_i,
  input  logic [reg_bus_pkg::ADDR_W-1:0]         cmd_addr_i,
  input  logic [reg_bus_pkg::DATA_W-1:0]         cmd_wdata_i,
  output logic                                   rsp_valid_o,
  input  logic                                   rsp_ready_i,
  output logic [reg_bus_pkg::DATA_W-1:0]         rsp_rdata_o,
  output logic                                   rsp_err_o,
  // board and radio status
  input  logic [board_map_pkg::BD_IN_W-1:0]      bd_in_i,
  input  logic [board_map_pkg::RADIO_STAT_W-1:0] radio0_stat_i,
  input  logic [board_map_pkg::RADIO_STAT_W-1:0] radio1_stat_i,
  // board and radio control
  output logic [board_map_pkg::BD_OUT_W-1:0]     bd_out_o,
  output logic [board_map_pkg::RADIO_CTL_W-1:0]  radio0_ctl_o,
  output logic                                   radio0_agc_o,
  output logic                                   radio0_enable_o,
  output logic                                   radio0_txnrx_o,
  output logic                                   radio0_resetb_o,
  output logic [board_map_pkg::RADIO_CTL_W-1:0]  radio1_ctl_o,
  output logic                                   radio1_agc_o,
  output logic                                   radio1_enable_o,
  output logic                                   radio1_txnrx_o,
  output logic                                   radio1_resetb_o,
  output logic [board_map_pkg::SPI_CS_W-1:0]     spi_cs_n_o,
  output logic                                   mcs_sync_o
);

  logic sync_req;

  reg_bus_if bus_if ();

  reg_access_port u_access (
    .s_ref_clk     (s_ref_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_wdata_i   (cmd_wdata_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o),
    .bus           (bus_if.master)
  );

  gpio_bank u_bank (
    .s_ref_clk       (s_ref_clk),
    .s_axi_aresetn   (s_axi_aresetn),
    .bus             (bus_if.slave),
    .bd_in_i         (bd_in_i),
    .radio0_stat_i   (radio0_stat_i),
    .radio1_stat_i   (radio1_stat_i),
    .bd_out_o        (bd_out_o),
    .sync_req_o      (sync_req),
    .radio0_ctl_o    (radio0_ctl_o),
    .radio0_agc_o    (radio0_agc_o),
    .radio0_enable_o (radio0_enable_o),
    .radio0_txnrx_o  (radio0_txnrx_o),
    .radio0_resetb_o (radio0_resetb_o),
    .radio1_ctl_o    (radio1_ctl_o),
    .radio1_agc_o    (radio1_agc_o),
    .radio1_enable_o (radio1_enable_o),
    .radio1_txnrx_o  (radio1_txnrx_o),
    .radio1_resetb_o (radio1_resetb_o),
    .spi_cs_n_o      (spi_cs_n_o)
  );

  mcs_sync_gen u_mcs (
    .s_ref_clk     (s_ref_clk),
    .s_axi_aresetn (s_axi_aresetn),
    .sync_req_i    (sync_req),
    .mcs_sync_o    (mcs_sync_o)
  );

endmodule

//--- verif/radio_ctrl_tb.sv
// radio control plane testbench
// runs the command lines of the test file through the command port
// and checks responses, board outputs and multi-chip sync pulses

module radio_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import reg_bus_pkg::*;
  import board_map_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int LINE_CYCLES     = 200;
  localparam int HANDSHAKE_LIMIT = 50;
  localparam int NAME_W          = 96;

  logic                    s_ref_clk;
  logic                    s_axi_aresetn;
  logic                    cmd_valid_i;
  logic                    cmd_ready_o;
  reg_op_e                 cmd_op_i;
  logic [ADDR_W-1:0]       cmd_addr_i;
  logic [DATA_W-1:0]       cmd_wdata_i;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  logic [DATA_W-1:0]       rsp_rdata_o;
  logic                    rsp_err_o;
  logic [BD_IN_W-1:0]      bd_in_i;
  logic [RADIO_STAT_W-1:0] radio0_stat_i;
  logic [RADIO_STAT_W-1:0] radio1_stat_i;
  logic [BD_OUT_W-1:0]     bd_out_o;
  logic [RADIO_CTL_W-1:0]  radio0_ctl_o;
  logic                    radio0_agc_o;
  logic                    radio0_enable_o;
  logic                    radio0_txnrx_o;
  logic                    radio0_resetb_o;
  logic [RADIO_CTL_W-1:0]  radio1_ctl_o;
  logic                    radio1_agc_o;
  logic                    radio1_enable_o;
  logic                    radio1_txnrx_o;
  logic                    radio1_resetb_o;
  logic [SPI_CS_W-1:0]     spi_cs_n_o;
  logic                    mcs_sync_o;

  int   test_lines  = 0;
  int   sync_pulses = 0;
  logic sync_last   = 1'b0;

  radio_ctrl_top uut (.*);

  always #(CLK_PERIOD / 2) s_ref_clk = ~s_ref_clk;

  task automatic value_mismatch(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  function automatic bit is_test_line(input string line);
    return line.len() > 0 && line[0] != "#" && line[0] != "\n";
  endfunction

  task automatic sample_output(input logic [NAME_W-1:0] name, output logic [DATA_W-1:0] value);
    case (name)
      NAME_W'("bd_out"):    value = DATA_W'(bd_out_o);
      NAME_W'("r0_ctl"):    value = DATA_W'(radio0_ctl_o);
      NAME_W'("r0_agc"):    value = DATA_W'(radio0_agc_o);
      NAME_W'("r0_enable"): value = DATA_W'(radio0_enable_o);
      NAME_W'("r0_txnrx"):  value = DATA_W'(radio0_txnrx_o);
      NAME_W'("r0_resetb"): value = DATA_W'(radio0_resetb_o);
      NAME_W'("r1_ctl"):    value = DATA_W'(radio1_ctl_o);
      NAME_W'("r1_agc"):    value = DATA_W'(radio1_agc_o);
      NAME_W'("r1_enable"): value = DATA_W'(radio1_enable_o);
      NAME_W'("r1_txnrx"):  value = DATA_W'(radio1_txnrx_o);
      NAME_W'("r1_resetb"): value = DATA_W'(radio1_resetb_o);
      NAME_W'("spi_cs_n"):  value = DATA_W'(spi_cs_n_o);
      NAME_W'("mcs_sync"):  value = DATA_W'(mcs_sync_o);
      default: abort_run($sformatf("the test file names an unknown output %0s", name));
    endcase
  endtask

  // control outputs follow the data of a write the bank accepted
  task automatic check_written_fields(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data);
    logic [RADIO_REG_W-1:0] exp_bits;
    logic [RADIO_REG_W-1:0] seen_bits;
    exp_bits  = {data[FLD_RESETB], data[FLD_TXNRX], data[FLD_ENABLE], data[FLD_AGC],
                 data[FLD_CTL +: RADIO_CTL_W]};
    seen_bits = '0;
    case (addr)
      ADDR_RADIO0_CTRL: begin
        seen_bits = {radio0_resetb_o, radio0_txnrx_o, radio0_enable_o, radio0_agc_o,
                     radio0_ctl_o};
      end
      ADDR_RADIO1_CTRL: begin
        seen_bits = {radio1_resetb_o, radio1_txnrx_o, radio1_enable_o, radio1_agc_o,
                     radio1_ctl_o};
      end
      ADDR_BOARD_CTRL: begin
        exp_bits  = RADIO_REG_W'(data[FLD_BD_OUT +: BD_OUT_W]);
        seen_bits = RADIO_REG_W'(bd_out_o);
      end
      default: abort_run("the test file expects a write to a read-only address to succeed");
    endcase
    assert (seen_bits == exp_bits) else value_mismatch($sformatf(
      "outputs of address %0d are %h after writing %h, expected %h",
      addr, seen_bits, data, exp_bits));
  endtask

  //**********************************************************************
  // one command through the port, called and returning on a falling edge
  //**********************************************************************
  task automatic run_command(input reg_op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata, output logic err);
    int                waited;
    logic [DATA_W-1:0] held_rdata;
    logic              held_err;
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_addr_i  = addr;
    cmd_wdata_i = wdata;
    waited      = 0;
    while (!cmd_ready_o) begin
      @(negedge s_ref_clk);
      waited++;
      if (waited > HANDSHAKE_LIMIT) abort_run("the command port never became ready");
    end
    // accepted on the coming rising edge
    @(negedge s_ref_clk);
    cmd_valid_i = 1'b0;
    assert (rsp_valid_o) else value_mismatch("no response one cycle after accept");
    held_rdata = rsp_rdata_o;
    held_err   = rsp_err_o;
    // random back-pressure, response must hold and port stays closed
    do begin
      assert (rsp_valid_o && !cmd_ready_o)
        else value_mismatch("response dropped or command port open while pending");
      assert (rsp_rdata_o == held_rdata && rsp_err_o == held_err)
        else value_mismatch("response payload changed while stalled");
      rsp_ready_i = ($urandom % 4) != 0;
      if (!rsp_ready_i) @(negedge s_ref_clk);
    end while (!rsp_ready_i);
    @(negedge s_ref_clk);
    rsp_ready_i = 1'b0;
    assert (!rsp_valid_o) else value_mismatch("second response for one command");
    rdata = held_rdata;
    err   = held_err;
  endtask

  task automatic run_test_line(input string line);
    int                n;
    logic [7:0]        kind;
    logic [NAME_W-1:0] name;
    logic [31:0]       p1;
    logic [31:0]       p2;
    logic [31:0]       p3;
    logic [DATA_W-1:0] value;
    logic              err;
    n = $sscanf(line, "%c", kind);
    case (kind)
      "W", "R": begin
        n = $sscanf(line, "%c %h %h %h", kind, p1, p2, p3);
        if (n != 4) abort_run($sformatf("malformed test line: %s", line));
        if (kind == "W") begin
          run_command(OP_WRITE, p1[ADDR_W-1:0], p2[DATA_W-1:0], value, err);
          if (p3[0] == 1'b0) check_written_fields(p1[ADDR_W-1:0], p2[DATA_W-1:0]);
        end else begin
          run_command(OP_READ, p1[ADDR_W-1:0], '0, value, err);
          assert (value == p2[DATA_W-1:0]) else value_mismatch($sformatf(
            "read of address %0d returned %h, expected %h", p1, value, p2[DATA_W-1:0]));
        end
        assert (err == p3[0]) else value_mismatch($sformatf(
          "%c at address %0d gave err %0b, expected %0b", kind, p1, err, p3[0]));
      end
      "I": begin
        n = $sscanf(line, "%c %h %h %h", kind, p1, p2, p3);
        if (n != 4) abort_run($sformatf("malformed test line: %s", line));
        bd_in_i       = p1[BD_IN_W-1:0];
        radio0_stat_i = p2[RADIO_STAT_W-1:0];
        radio1_stat_i = p3[RADIO_STAT_W-1:0];
      end
      "O": begin
        n = $sscanf(line, "%c %s %h", kind, name, p1);
        if (n != 3) abort_run($sformatf("malformed test line: %s", line));
        sample_output(name, value);
        assert (value == p1[DATA_W-1:0]) else value_mismatch($sformatf(
          "output %0s is %h, expected %h", name, value, p1[DATA_W-1:0]));
      end
      "S": begin
        n = $sscanf(line, "%c %h", kind, p1);
        if (n != 2) abort_run($sformatf("malformed test line: %s", line));
        // pulse lands three cycles after the write edge
        repeat (4) @(negedge s_ref_clk);
        assert (sync_pulses == int'(p1)) else value_mismatch($sformatf(
          "%0d sync pulses seen, expected %0d", sync_pulses, p1));
      end
      default: abort_run($sformatf("unknown test line kind %c", kind));
    endcase
  endtask

  // sync pulse monitor
  always @(negedge s_ref_clk) begin
    if (s_axi_aresetn) begin
      assert (!(mcs_sync_o && sync_last))
        else value_mismatch("mcs_sync_o high for more than one cycle");
      if (mcs_sync_o) sync_pulses <= sync_pulses + 1;
    end
    sync_last <= mcs_sync_o;
  end

  initial begin : watchdog
    wait (test_lines > 0);
    #((test_lines * LINE_CYCLES + 10) * CLK_PERIOD);
    abort_run("timeout, the tests did not finish in time");
  end

  //**********************************************************************
  // main sequence
  //**********************************************************************
  initial begin : main
    int    fd;
    int    code;
    string line;
    void'($urandom(32'hf464_4f41));
    s_ref_clk     = 1'b0;
    s_axi_aresetn = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_op_i      = OP_READ;
    cmd_addr_i    = '0;
    cmd_wdata_i   = '0;
    rsp_ready_i   = 1'b0;
    bd_in_i       = '0;
    radio0_stat_i = '0;
    radio1_stat_i = '0;

    // first pass sizes the watchdog
    fd = $fopen("verif/radio_ctrl_tests.txt", "r");
    if (fd == 0) abort_run("could not open verif/radio_ctrl_tests.txt");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && is_test_line(line)) test_lines++;
    end
    $fclose(fd);

    repeat (4) @(negedge s_ref_clk);
    assert (!cmd_ready_o && !rsp_valid_o && !mcs_sync_o && spi_cs_n_o == 3'b111)
      else value_mismatch("port or outputs active during reset");
    s_axi_aresetn = 1'b1;

    fd = $fopen("verif/radio_ctrl_tests.txt", "r");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && is_test_line(line)) run_test_line(line);
    end
    $fclose(fd);
    repeat (2) @(negedge s_ref_clk);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- verif/radio_ctrl_tests.txt
# W addr data err | R addr data err | I board stat0 stat1 | S pulse_count
# O output_name value   (all numbers hex)
O r0_resetb 0
O r1_resetb 0
O r0_enable 0
O r1_enable 0
O r0_agc 0
O r1_agc 0
O spi_cs_n 7
O mcs_sync 0
R 0 0000 0
R 2 0000 0
R 3 0000 0
W 2 FFFF 0
R 2 00FF 0
O r0_ctl F
O r0_resetb 1
O r0_txnrx 1
W 3 00A5 0
R 3 00A5 0
O r1_ctl 5
O r1_enable 1
O r1_agc 0
O r1_resetb 1
W 0 FF2B 0
R 0 002B 0
O bd_out B
O spi_cs_n 6
W 0 0040 0
O spi_cs_n 5
W 0 0060 0
O spi_cs_n 3
I A5 3C C3
R 1 00A5 0
R 4 003C 0
R 5 00C3 0
W 1 1234 1
W 5 FFFF 1
W 7 FFFF 1
R 6 0000 1
R 7 0000 1
O spi_cs_n 3
O r1_ctl 5
O bd_out 0
W 0 0010 0
S 0
W 0 0000 0
S 1
O spi_cs_n 7
W 0 0013 0
W 0 0003 0
S 2
O bd_out 3

//--- sim.f
rtl/reg_bus_pkg.sv
rtl/board_map_pkg.sv
rtl/reg_bus_if.sv
rtl/reg_access_port.sv
rtl/gpio_bank.sv
rtl/mcs_sync_gen.sv
rtl/radio_ctrl_top.sv
verif/radio_ctrl_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing -Wall
TOP        = radio_ctrl_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
